//--- src/qla_pkg.sv
//--------------------
// shared constants and bus types for the QLA motor-axis core
// only the main register region is decoded, all others read as zero
// current words are offset binary, 16'h8000 is zero current
// four axes fixed, channel n addresses axis n
//--------------------
package qla_pkg;

    // ------------------
    // sizes
    // ------------------
    localparam int NUM_AXES   = 4;
    localparam int CUR_W      = 16;                 // adc / dac word
    localparam int AXIS_IDX_W = $clog2(NUM_AXES);   // axis index within cur_vec_t
    localparam int LIMIT_W    = CUR_W + 2;          // 2*cmd + margin headroom

    // ------------------
    // address map
    // ------------------
    localparam logic [3:0] ADDR_MAIN    = 4'd0;     // region, addr[15:12]
    localparam logic [3:0] CHAN_BOARD   = 4'd0;     // channel 0 holds board i/o
    localparam logic [3:0] OFF_STATUS   = 4'd0;     // channel 0 only
    localparam logic [3:0] OFF_ADC_DATA = 4'd0;     // channels 1..4
    localparam logic [3:0] OFF_DAC_CTRL = 4'd1;     // channels 1..4

    // ------------------
    // safety check
    // ------------------
    localparam logic [CUR_W-1:0] CUR_MID       = 16'h8000;  // zero current
    localparam logic [CUR_W-1:0] SAFETY_MARGIN = 16'd1024;  // allowed excess, counts
    localparam int               SAFETY_CNT_W  = 3;
    localparam logic [SAFETY_CNT_W-1:0] SAFETY_COUNT = 3'd4; // samples before trip

    // status word bit positions
    localparam int PWR_EN_BIT   = 19;
    localparam int AMP_EN_LSB   = 8;    // NUM_AXES bits
    localparam int SAFETY_LSB   = 4;    // NUM_AXES bits, latched disables
    localparam int BOARD_ID_LSB = 24;   // 4 bits

    // ------------------
    // types
    // ------------------
    // register address split into its fields
    typedef struct packed {
        logic [3:0] region;     // [15:12]
        logic [3:0] unused;     // [11:8] ignored
        logic [3:0] chan;       // [7:4] 0 = board, 1..4 = axis
        logic [3:0] off;        // [3:0]
    } reg_addr_t;

    // one word per axis, index 0 is axis 1
    typedef logic [NUM_AXES-1:0][CUR_W-1:0] cur_vec_t;

    // host register write, wen is a single-cycle strobe
    typedef struct packed {
        logic        wen;
        logic [15:0] waddr;
        logic [31:0] wdata;
    } reg_wr_t;

    // parallel adc current feedback with its sample strobe
    typedef struct packed {
        logic     cur_ready;
        cur_vec_t cur_fb;
    } adc_sample_t;

endpackage

//--- src/axis_regs.sv
//--------------------
// host write side of the core
// status write sets power and amp enables and pulses the safety clears
// dac control write sets one axis command from wdata[15:0]
// no back-pressure, every strobe is taken
//--------------------
module axis_regs
    import qla_pkg::*;
(
    input  logic                sysclk,
    input  logic                rst_n,
    input  reg_wr_t             wr,             // write strobe, addr, data
    input  logic [NUM_AXES-1:0] amp_disable,    // latched safety trips
    output cur_vec_t            cur_cmd,        // commands toward the dacs
    output logic                pwr_enable,
    output logic [NUM_AXES-1:0] amp_enable,
    output logic [NUM_AXES-1:0] clear_disable   // one-cycle pulse per axis
);

    // ------------------
    // write decode
    // ------------------
    reg_addr_t             waddr;
    logic                  main_wr;     // strobe into the main region
    logic                  axis_chan;   // channel 1..NUM_AXES
    logic                  status_wr;
    logic                  dac_wr;
    logic [AXIS_IDX_W-1:0] wr_axis;     // channel n -> index n-1
    logic [NUM_AXES-1:0]   clr_req;     // clear request per axis

    assign waddr     = reg_addr_t'(wr.waddr);
    assign main_wr   = wr.wen && (waddr.region == ADDR_MAIN);
    assign axis_chan = (waddr.chan != CHAN_BOARD) && (waddr.chan <= 4'(NUM_AXES));
    assign status_wr = main_wr && (waddr.chan == CHAN_BOARD) && (waddr.off == OFF_STATUS);
    assign dac_wr    = main_wr && axis_chan && (waddr.off == OFF_DAC_CTRL);
    assign wr_axis   = AXIS_IDX_W'(waddr.chan - 4'd1);

    // power bit clears every axis, amp bit only its own
    always_comb begin
        for (int i = 0; i < NUM_AXES; i++) begin
            clr_req[i] = status_wr && (wr.wdata[PWR_EN_BIT] || wr.wdata[AMP_EN_LSB + i]);
        end
    end

    // ------------------
    // current commands
    // ------------------
    always_ff @(posedge sysclk or negedge rst_n) begin
        if (!rst_n) begin
            cur_cmd <= '0;
        end else if (dac_wr) begin
            cur_cmd[wr_axis] <= wr.wdata[CUR_W-1:0];    // low half only
        end
    end

    // ------------------
    // power enable
    // ------------------
    always_ff @(posedge sysclk or negedge rst_n) begin
        if (!rst_n) begin
            pwr_enable <= 1'b0;
        end else if (status_wr) begin
            pwr_enable <= wr.wdata[PWR_EN_BIT];
        end
    end

    // ------------------
    // amp enables
    // ------------------
    // a trip drops the enable, a status write in the same cycle wins.
    // while a clear pulse is out the disable is about to fall, so it is
    // ignored for that one cycle
    always_ff @(posedge sysclk or negedge rst_n) begin
        if (!rst_n) begin
            amp_enable <= '0;
        end else begin
            for (int i = 0; i < NUM_AXES; i++) begin
                if (status_wr) begin
                    amp_enable[i] <= wr.wdata[AMP_EN_LSB + i];
                end else if (amp_disable[i] && !clear_disable[i]) begin
                    amp_enable[i] <= 1'b0;  // safety trip
                end
            end
        end
    end

    // clear pulses, one cycle after the strobe
    always_ff @(posedge sysclk or negedge rst_n) begin
        if (!rst_n) begin
            clear_disable <= '0;
        end else begin
            clear_disable <= clr_req;   // self-clearing, no hold
        end
    end

endmodule

//--- src/safety_check.sv
//--------------------
// per-axis over-current check
// trips after SAFETY_COUNT consecutive samples with
// |fb| > 2*|cmd| + SAFETY_MARGIN, magnitudes taken about CUR_MID
// the trip latches until clear_disable
//--------------------
module safety_check
    import qla_pkg::*;
(
    input  logic             sysclk,
    input  logic             rst_n,
    input  logic             cur_ready,      // adc sample strobe
    input  logic [CUR_W-1:0] cur_fb,         // feedback, offset binary
    input  logic [CUR_W-1:0] cur_cmd,        // command, offset binary
    input  logic             clear_disable,  // host clear pulse
    output logic             amp_disable     // latched trip
);

    // ------------------
    // magnitude compare
    // ------------------
    logic [CUR_W-1:0]        fb_mag;
    logic [CUR_W-1:0]        cmd_mag;
    logic [LIMIT_W-1:0]      limit;         // 2*cmd_mag + margin
    logic                    violation;
    logic [SAFETY_CNT_W-1:0] viol_cnt;      // consecutive violating samples
    logic [SAFETY_CNT_W-1:0] cnt_nxt;

    // distance from midscale, either sign
    assign fb_mag  = (cur_fb  >= CUR_MID) ? (cur_fb  - CUR_MID) : (CUR_MID - cur_fb);
    assign cmd_mag = (cur_cmd >= CUR_MID) ? (cur_cmd - CUR_MID) : (CUR_MID - cur_cmd);

    // 18 bit sum so 2*0x8000 + margin cannot wrap
    assign limit     = {1'b0, cmd_mag, 1'b0} + {2'b00, SAFETY_MARGIN};
    assign violation = {2'b00, fb_mag} > limit;

    // saturate at the trip count, a good sample restarts the run
    always_comb begin
        if (!violation) begin
            cnt_nxt = '0;
        end else if (viol_cnt == SAFETY_COUNT) begin
            cnt_nxt = viol_cnt;
        end else begin
            cnt_nxt = viol_cnt + 1'b1;
        end
    end

    // ------------------
    // counter and latch
    // ------------------
    always_ff @(posedge sysclk or negedge rst_n) begin
        if (!rst_n) begin
            viol_cnt    <= '0;
            amp_disable <= 1'b0;
        end else if (clear_disable) begin
            viol_cnt    <= '0;      // clear wins over a sample
            amp_disable <= 1'b0;
        end else if (cur_ready) begin
            viol_cnt <= cnt_nxt;
            if (cnt_nxt == SAFETY_COUNT) begin
                amp_disable <= 1'b1;    // holds until next clear
            end
        end
    end

endmodule

//--- src/reg_read_mux.sv
//--------------------
// register read side
// reg_rdata follows reg_raddr by one clock
// only the main region is decoded, anything else reads zero
//--------------------
module reg_read_mux
    import qla_pkg::*;
(
    input  logic                sysclk,
    input  logic                rst_n,
    input  logic [15:0]         reg_raddr,
    input  logic [3:0]          board_id,       // rotary switch
    input  logic                pwr_enable,
    input  logic [NUM_AXES-1:0] amp_enable,
    input  logic [NUM_AXES-1:0] amp_disable,    // safety trips
    input  cur_vec_t            cur_cmd,
    input  cur_vec_t            cur_fb,
    output logic [31:0]         reg_rdata
);

    reg_addr_t             raddr;
    logic                  main_rd;
    logic                  axis_chan;       // channel 1..NUM_AXES
    logic [AXIS_IDX_W-1:0] rd_axis;
    logic [31:0]           status_word;
    logic [31:0]           rdata_nxt;

    assign raddr     = reg_addr_t'(reg_raddr);
    assign main_rd   = (raddr.region == ADDR_MAIN);
    assign axis_chan = (raddr.chan != CHAN_BOARD) && (raddr.chan <= 4'(NUM_AXES));
    assign rd_axis   = AXIS_IDX_W'(raddr.chan - 4'd1);

    // ------------------
    // status word
    // ------------------
    always_comb begin
        status_word = '0;   // undefined bits read zero
        status_word[BOARD_ID_LSB +: 4]      = board_id;
        status_word[PWR_EN_BIT]             = pwr_enable;
        status_word[AMP_EN_LSB +: NUM_AXES] = amp_enable;
        status_word[SAFETY_LSB +: NUM_AXES] = amp_disable;
    end

    // ------------------
    // address select
    // ------------------
    always_comb begin
        rdata_nxt = '0;
        if (main_rd) begin
            if (raddr.chan == CHAN_BOARD) begin
                if (raddr.off == OFF_STATUS) begin
                    rdata_nxt = status_word;
                end
            end else if (axis_chan) begin
                case (raddr.off)
                    OFF_ADC_DATA: rdata_nxt = {16'h0000, cur_fb[rd_axis]};   // zero-extended
                    OFF_DAC_CTRL: rdata_nxt = {16'h0000, cur_cmd[rd_axis]};
                    default:      rdata_nxt = '0;
                endcase
            end
        end
    end

    // registered read data
    always_ff @(posedge sysclk or negedge rst_n) begin
        if (!rst_n) begin
            reg_rdata <= '0;
        end else begin
            reg_rdata <= rdata_nxt;
        end
    end

endmodule

//--- src/qla_core_top.sv
//--------------------
// QLA motor-axis core, register bus in and out
// adc words arrive already parallel with a sample strobe
// cur_cmd goes to an external dac engine
//--------------------
module qla_core_top
    import qla_pkg::*;
(
    input  logic                sysclk,
    input  logic                rst_n,
    input  logic [3:0]          board_id,   // rotary switch, as given
    input  reg_wr_t             wr,         // host register write
    input  logic [15:0]         reg_raddr,
    input  adc_sample_t         adc,        // current feedback samples
    output logic [31:0]         reg_rdata,
    output logic                pwr_enable,
    output logic [NUM_AXES-1:0] amp_enable,
    output cur_vec_t            cur_cmd     // toward the dacs
);

    logic [NUM_AXES-1:0] clear_disable;     // write bank -> safety
    logic [NUM_AXES-1:0] amp_disable;       // safety -> write bank, readback

    // ------------------
    // write bank
    // ------------------
    axis_regs u_axis_regs (
        .sysclk        (sysclk),
        .rst_n         (rst_n),
        .wr            (wr),
        .amp_disable   (amp_disable),
        .cur_cmd       (cur_cmd),
        .pwr_enable    (pwr_enable),
        .amp_enable    (amp_enable),
        .clear_disable (clear_disable)
    );

    // ------------------
    // safety checks
    // ------------------
    for (genvar i = 0; i < NUM_AXES; i++) begin : g_safety
        safety_check u_safety (
            .sysclk        (sysclk),
            .rst_n         (rst_n),
            .cur_ready     (adc.cur_ready),     // shared strobe
            .cur_fb        (adc.cur_fb[i]),
            .cur_cmd       (cur_cmd[i]),
            .clear_disable (clear_disable[i]),
            .amp_disable   (amp_disable[i])
        );
    end

    // ------------------
    // read mux
    // ------------------
    reg_read_mux u_read_mux (
        .sysclk      (sysclk),
        .rst_n       (rst_n),
        .reg_raddr   (reg_raddr),
        .board_id    (board_id),
        .pwr_enable  (pwr_enable),
        .amp_enable  (amp_enable),
        .amp_disable (amp_disable),
        .cur_cmd     (cur_cmd),
        .cur_fb      (adc.cur_fb),
        .reg_rdata   (reg_rdata)
    );

endmodule

//--- bench/tb_qla_core.sv
//--------------------
// testbench for qla_core_top, checks against a register model in the bench
// inputs change on the rising edge, outputs are sampled on the falling edge
// fixed random seed, every wait is bounded
//--------------------
module tb_qla_core
    import qla_pkg::*;
();
    timeunit 1ns;
    timeprecision 1ps;

    localparam logic [3:0] BOARD_ID = 4'h6;    // rotary switch value
    localparam int         WAIT_MAX = 16;      // cycles before a wait gives up

    logic                sysclk;
    logic                rst_n;
    reg_wr_t             wr;
    logic [15:0]         reg_raddr;
    adc_sample_t         adc;
    logic [31:0]         reg_rdata;
    logic                pwr_enable;
    logic [NUM_AXES-1:0] amp_enable;
    cur_vec_t            cur_cmd;

    // ------------------
    // reference model
    // ------------------
    cur_vec_t            exp_cmd;
    logic                exp_pwr;
    logic [NUM_AXES-1:0] exp_amp;
    logic [NUM_AXES-1:0] exp_dis;      // latched safety disables
    int                  exp_cnt [NUM_AXES];
    int                  errors;
    int                  checks;
    int                  tests_run;
    int                  tests_failed;
    int                  test_err0;    // error count when the test began
    string               test_name;

    qla_core_top u_dut (
        .sysclk     (sysclk),
        .rst_n      (rst_n),
        .board_id   (BOARD_ID),
        .wr         (wr),
        .reg_raddr  (reg_raddr),
        .adc        (adc),
        .reg_rdata  (reg_rdata),
        .pwr_enable (pwr_enable),
        .amp_enable (amp_enable),
        .cur_cmd    (cur_cmd)
    );

    initial sysclk = 1'b0;
    always #50 sysclk = ~sysclk;    // 100 ns period

    // a clear pulse drops the latched disable on the next edge
    clear_drops_disable: assert property (@(posedge sysclk) disable iff (!rst_n)
        (u_dut.clear_disable != '0) |=> ((u_dut.amp_disable & $past(u_dut.clear_disable)) == '0))
        else begin
            errors++;
            $display("safety disable still set after a clear pulse at %0t", $time);
        end

    // ------------------
    // model rules
    // ------------------
    function automatic int magnitude(logic [CUR_W-1:0] w);
        int v;
        v = int'(w) - int'(CUR_MID);    // offset binary about midscale
        return (v < 0) ? -v : v;
    endfunction

    function automatic int trip_limit(logic [CUR_W-1:0] cmd);
        return 2 * magnitude(cmd) + int'(SAFETY_MARGIN);
    endfunction

    function automatic logic [CUR_W-1:0] from_magnitude(int mag);
        if ($urandom % 2) begin
            return CUR_W'(int'(CUR_MID) + mag);
        end else begin
            return CUR_W'(int'(CUR_MID) - mag);
        end
    endfunction

    function automatic logic [15:0] reg_addr(logic [3:0] region, logic [3:0] chan, logic [3:0] off);
        return {region, 4'h0, chan, off};
    endfunction

    function automatic logic [31:0] expected_status();
        logic [31:0] w;
        w = '0;
        w[BOARD_ID_LSB +: 4]      = BOARD_ID;
        w[PWR_EN_BIT]             = exp_pwr;
        w[AMP_EN_LSB +: NUM_AXES] = exp_amp;
        w[SAFETY_LSB +: NUM_AXES] = exp_dis;
        return w;
    endfunction

    function automatic void model_write(logic [15:0] addr, logic [31:0] data);
        int chan;
        chan = int'(addr[7:4]);
        if (addr[15:12] != ADDR_MAIN) begin
            return;                 // other regions ignored
        end
        if (chan == 0 && addr[3:0] == OFF_STATUS) begin
            exp_pwr = data[PWR_EN_BIT];
            exp_amp = data[AMP_EN_LSB +: NUM_AXES];
            for (int i = 0; i < NUM_AXES; i++) begin
                if (data[PWR_EN_BIT] || data[AMP_EN_LSB + i]) begin
                    exp_dis[i] = 1'b0;
                    exp_cnt[i] = 0;
                end
            end
        end else if (chan >= 1 && chan <= NUM_AXES && addr[3:0] == OFF_DAC_CTRL) begin
            exp_cmd[chan - 1] = data[CUR_W-1:0];
        end
    endfunction

    // returns the axes that trip on this sample
    function automatic logic [NUM_AXES-1:0] model_sample(cur_vec_t fb);
        logic [NUM_AXES-1:0] trips;
        trips = '0;
        for (int i = 0; i < NUM_AXES; i++) begin
            if (magnitude(fb[i]) > trip_limit(exp_cmd[i])) begin
                if (exp_cnt[i] < int'(SAFETY_COUNT)) exp_cnt[i]++;    // saturates
            end else begin
                exp_cnt[i] = 0;
            end
            if (exp_cnt[i] == int'(SAFETY_COUNT) && !exp_dis[i]) begin
                exp_dis[i] = 1'b1;
                exp_amp[i] = 1'b0;
                trips[i]   = 1'b1;
            end
        end
        return trips;
    endfunction

    // ------------------
    // bus tasks
    // ------------------
    task automatic check_word(string what, logic [31:0] exp, logic [31:0] got);
        checks++;
        assert (got === exp) else begin
            errors++;
            $display("mismatch %s %s: expected %08h, actual %08h", test_name, what, exp, got);
        end
    endtask

    task automatic write_reg(logic [15:0] addr, logic [31:0] data);
        @(posedge sysclk);
        wr.wen   <= 1'b1;
        wr.waddr <= addr;
        wr.wdata <= data;
        @(posedge sysclk);          // strobe sampled here
        wr.wen <= 1'b0;
        model_write(addr, data);
        @(negedge sysclk);
    endtask

    task automatic read_reg(logic [15:0] addr, output logic [31:0] data);
        @(posedge sysclk);
        reg_raddr <= addr;
        @(posedge sysclk);          // address sampled, data registered
        @(negedge sysclk);
        data = reg_rdata;
    endtask

    task automatic send_sample(cur_vec_t fb);
        logic [NUM_AXES-1:0] tripped;
        int                  waited;
        @(posedge sysclk);
        adc.cur_ready <= 1'b1;
        adc.cur_fb    <= fb;        // held after the strobe
        @(posedge sysclk);
        adc.cur_ready <= 1'b0;
        tripped = model_sample(fb);
        @(negedge sysclk);
        waited = 0;
        while (((amp_enable & tripped) != '0) && waited < WAIT_MAX) begin
            @(negedge sysclk);
            waited++;
        end
        if ((amp_enable & tripped) != '0) begin
            errors++;
            $display("timeout in %s: amp_enable never dropped after a trip", test_name);
        end
    endtask

    task automatic check_outputs();
        logic [31:0] rd;
        check_word("pwr_enable", 32'(exp_pwr), 32'(pwr_enable));
        check_word("amp_enable", 32'(exp_amp), 32'(amp_enable));
        for (int i = 0; i < NUM_AXES; i++) begin
            check_word($sformatf("cur_cmd[%0d]", i), 32'(exp_cmd[i]), 32'(cur_cmd[i]));
        end
        read_reg(reg_addr(ADDR_MAIN, CHAN_BOARD, OFF_STATUS), rd);
        check_word("status", expected_status(), rd);
    endtask

    task automatic start_test(string name);
        test_name = name;
        test_err0 = errors;
    endtask

    task automatic end_test();
        tests_run++;
        if (errors == test_err0) begin
            $display("test %s: ok", test_name);
        end else begin
            tests_failed++;
            $display("test %s: failed with %0d errors", test_name, errors - test_err0);
        end
    endtask

    // ------------------
    // test sequence
    // ------------------
    initial begin
        logic [31:0] rd;
        logic [31:0] data;
        cur_vec_t    fb;
        int          axis;
        void'($urandom(32'hedfd));
        errors        = 0;
        checks        = 0;
        tests_run     = 0;
        tests_failed  = 0;
        rst_n         = 1'b0;
        wr            = '0;
        reg_raddr     = '0;
        adc.cur_ready = 1'b0;
        adc.cur_fb    = {NUM_AXES{CUR_MID}};  // zero current
        exp_cmd       = '0;
        exp_pwr       = 1'b0;
        exp_amp       = '0;
        exp_dis       = '0;
        foreach (exp_cnt[i]) exp_cnt[i] = 0;

        start_test("reset");
        repeat (2) @(posedge sysclk);
        check_word("reg_rdata in reset", 32'h0, reg_rdata);
        rst_n <= 1'b1;
        @(negedge sysclk);
        check_outputs();            // status holds only board_id
        end_test();

        start_test("cmd_write");
        for (int i = 0; i < NUM_AXES; i++) begin
            write_reg(reg_addr(ADDR_MAIN, 4'(i + 1), OFF_DAC_CTRL), $urandom);
            read_reg(reg_addr(ADDR_MAIN, 4'(i + 1), OFF_DAC_CTRL), rd);
            check_word($sformatf("cmd readback axis %0d", i + 1), 32'(exp_cmd[i]), rd);
        end
        write_reg(reg_addr(4'h1, 4'h1, OFF_DAC_CTRL), $urandom);     // wrong region
        write_reg(reg_addr(ADDR_MAIN, 4'h2, 4'h7), $urandom);        // undefined offset
        write_reg(reg_addr(ADDR_MAIN, 4'h5, OFF_DAC_CTRL), $urandom); // no such axis
        check_outputs();
        read_reg(reg_addr(4'h1, 4'h1, OFF_DAC_CTRL), rd);
        check_word("other region read", 32'h0, rd);
        read_reg(reg_addr(ADDR_MAIN, 4'h2, 4'h7), rd);
        check_word("undefined offset read", 32'h0, rd);
        read_reg(reg_addr(4'h3, CHAN_BOARD, OFF_STATUS), rd);
        check_word("status in other region", 32'h0, rd);
        end_test();

        start_test("adc_readback");
        repeat (2) begin
            for (int i = 0; i < NUM_AXES; i++) fb[i] = CUR_W'($urandom);
            send_sample(fb);
            for (int i = 0; i < NUM_AXES; i++) begin
                read_reg(reg_addr(ADDR_MAIN, 4'(i + 1), OFF_ADC_DATA), rd);
                check_word($sformatf("adc readback axis %0d", i + 1), 32'(fb[i]), rd);
            end
        end
        send_sample({NUM_AXES{CUR_MID}});   // restart the violation runs
        end_test();

        start_test("enable_write");
        repeat (3) begin
            data = '0;
            data[PWR_EN_BIT] = 1'($urandom);
            data[AMP_EN_LSB +: NUM_AXES] = NUM_AXES'($urandom);
            write_reg(reg_addr(ADDR_MAIN, CHAN_BOARD, OFF_STATUS), data);
            check_outputs();
        end
        end_test();

        start_test("safety_trip");
        axis = $urandom % NUM_AXES;
        data = '0;
        data[PWR_EN_BIT] = 1'b1;
        data[AMP_EN_LSB +: NUM_AXES] = '1;
        write_reg(reg_addr(ADDR_MAIN, CHAN_BOARD, OFF_STATUS), data);
        write_reg(reg_addr(ADDR_MAIN, 4'(axis + 1), OFF_DAC_CTRL),
                  {16'h0, from_magnitude($urandom % 512)});
        fb = {NUM_AXES{CUR_MID}};
        // short runs, each ended by a good sample
        for (int n = 1; n < int'(SAFETY_COUNT); n++) begin
            repeat (n) begin
                fb[axis] = from_magnitude(trip_limit(exp_cmd[axis]) + 1 + int'($urandom % 256));
                send_sample(fb);
            end
            fb[axis] = CUR_MID;
            send_sample(fb);
            check_outputs();
        end
        repeat (SAFETY_COUNT) begin
            fb[axis] = from_magnitude(trip_limit(exp_cmd[axis]) + 1 + int'($urandom % 256));
            send_sample(fb);
        end
        check_word("tripped amp_enable bit", 32'h0, 32'(amp_enable[axis]));
        check_outputs();            // other axes keep their enables
        end_test();

        start_test("safety_clear");
        data = '0;
        data[AMP_EN_LSB +: NUM_AXES] = '1;  // amp bits only, power off
        write_reg(reg_addr(ADDR_MAIN, CHAN_BOARD, OFF_STATUS), data);
        check_outputs();
        repeat (6) begin
            fb[axis] = from_magnitude(int'($urandom % (trip_limit(exp_cmd[axis]) + 1)));
            send_sample(fb);
        end
        check_outputs();
        end_test();

        $display("tests run %0d, failed %0d, checks %0d, errors %0d",
                 tests_run, tests_failed, checks, errors);
        if (errors == 0) begin
            $display("All tests passed");
        end else begin
            $display("Some tests failed");
        end
        $finish;
    end

endmodule

//--- vlog.f
src/qla_pkg.sv
src/axis_regs.sv
src/safety_check.sv
src/reg_read_mux.sv
src/qla_core_top.sv
bench/tb_qla_core.sv

//--- Bender.yml
package:
  name: qla_core

dependencies: {}

sources:
  # package first, then the design bottom up
  - src/qla_pkg.sv
  - src/axis_regs.sv
  - src/safety_check.sv
  - src/reg_read_mux.sv
  - src/qla_core_top.sv

  # simulation only
  - target: test
    files:
      - bench/tb_qla_core.sv
